// ==== sources.f ====
logic/analyser_pkg.sv
logic/freq_div.sv
logic/uart_tx.sv
logic/sample_ctrl.sv
logic/capture_ram.sv
logic/pulse_gen.sv
logic/top_analyser.sv
bench/tb_top_analyser.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module tb_top_analyser -f sources.f -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== bench/tb_top_analyser.sv ====
`timescale 1ns/1ps

module tb_top_analyser;

   localparam int CLK_PERIOD  = 4;
   localparam int BAUD_DIV    = 16;
   localparam int ARM_DELAY   = 8;
   localparam int FORCE_AFTER = 64;                 // wait samples before a forced trigger
   localparam int NUM_CAPS    = 10;
   localparam int CAP_CYCLES  = ARM_DELAY + (1024 + FORCE_AFTER + 2) * 8 + 1024 + 100;

   logic                     clk;
   logic                     rst_n;
   analyser_pkg::sample_t    probe;
   logic                     run;
   logic                     uart_en;
   analyser_pkg::sample_t    tx_byte;
   analyser_pkg::chan_t      chn_sel;
   analyser_pkg::trig_mode_t mode_sel;
   analyser_pkg::freq_sel_t  freq_sel;
   analyser_pkg::addr_t      pre_num;
   analyser_pkg::addr_t      rd_addr;
   analyser_pkg::sample_t    rd_data;
   analyser_pkg::addr_t      start_addr;
   logic                     done;
   logic                     busy;
   logic                     tx;

   logic [31:0]              seed = 32'd66690;
   analyser_pkg::sample_t    mmem [1024];           // model of the capture memory
   analyser_pkg::sample_t    rd_buf [1024];         // trace as read back
   analyser_pkg::sample_t    mprev;                 // model edge reference
   analyser_pkg::sample_t    ubyte;                 // byte of the modelled uart frame
   analyser_pkg::trig_mode_t mmode;
   int                       mchn, mpre, mstart, wptr, mcnt, wait_cnt, mstate, cyc, done_at;
   int                       mhold;                 // clocks left before arm
   int                       upos;                  // clocks into the uart frame
   logic [15:0]              mc, mmask;             // model divider
   logic                     mactive;               // holdoff in progress
   logic                     uon;                   // uart frame in progress
   logic                     mtx;                   // expected uart line

   top_analyser #(
      .BAUD_DIV  (BAUD_DIV),
      .ARM_DELAY (ARM_DELAY)
   ) top_analyser_inst (
      .sys_clk(clk), .i_rst_n(rst_n), .i_probe(probe), .i_run(run), .i_uart_en(uart_en),
      .i_tx_byte(tx_byte), .i_chn_sel(chn_sel), .i_mode_sel(mode_sel), .i_freq_sel(freq_sel),
      .i_pre_num(pre_num), .i_rd_addr(rd_addr), .o_rd_data(rd_data),
      .o_start_addr(start_addr), .o_done(done), .o_busy(busy), .o_tx(tx)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed;
   endfunction

   // trigger condition on previous and current channel value
   function automatic logic trig_met(analyser_pkg::trig_mode_t m, logic p, logic c);
      case (m)
         analyser_pkg::TRIG_RISE: return !p && c;
         analyser_pkg::TRIG_FALL: return p && !c;
         analyser_pkg::TRIG_HIGH: return c;
         analyser_pkg::TRIG_LOW:  return !c;
         default:                 return 1'b1;       // fire on first wait sample
      endcase
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp) begin
         fail_run($sformatf("** Error at %0t: %s = %0h, expected %0h", $time, name, act, exp));
      end
   endtask

   // model of one posedge as seen at the following negedge
   task automatic model_step();
      analyser_pkg::sample_t s;
      logic                  ck;
      logic                  idle;
      logic                  arm_now;
      s = probe;
      if (uart_en) s[analyser_pkg::UART_CHAN] = mtx;  // line as seen at the edge
      cyc     = cyc + 1;
      idle    = (mstate == 0);                        // arm only counts in idle
      arm_now = mactive && (mhold == 0) && run;
      if (cyc - 2 == done_at) begin                   // finished reaches the holdoff
         mhold   = ARM_DELAY - 1;
         mactive = 1'b1;
      end else if (mactive) begin
         if (mhold == 0) begin
            mactive = 1'b0;                           // one arm per holdoff
         end else begin
            mhold = mhold - 1;
         end
      end
      if (mstate == 4) mstate = 0;                    // done lasts one cycle
      if (mc == 16'd0) mmask = (16'd1 << freq_sel) - 16'd1;
      ck = (mc == mmask);
      mc = ck ? 16'd0 : mc + 16'd1;
      if (ck && mstate >= 1 && mstate <= 3) begin
         mmem[wptr] = s;
         if (mstate == 1) begin
            mcnt = mcnt - 1;
            if (mcnt == 0) mstate = 2;
         end else if (mstate == 2) begin
            wait_cnt = wait_cnt + 1;
            if (trig_met(mmode, mprev[mchn], s[mchn])) begin
               mstart = (wptr - mpre) & 1023;
               mcnt   = 1023 - mpre;
               mstate = (mcnt == 0) ? 4 : 3;
            end
         end else begin
            mcnt = mcnt - 1;
            if (mcnt == 0) mstate = 4;
         end
         if (mstate == 4) done_at = cyc;
         wptr = (wptr + 1) & 1023;
      end
      if (ck) mprev = s;
      if (arm_now && idle) begin                      // arm taken on this edge
         mchn   = uart_en ? int'(analyser_pkg::UART_CHAN) : int'(chn_sel);
         mmode  = uart_en ? analyser_pkg::TRIG_FALL : mode_sel;
         mpre   = int'(pre_num);
         mcnt   = mpre;
         wptr   = 0;
         wait_cnt = 0;
         mstate = (mpre == 0) ? 2 : 1;
      end
      if (uon) begin
         upos = upos + 1;
         if (upos == 10 * BAUD_DIV) uon = 1'b0;       // stop bit over
      end
      if (!uon && uart_en) begin                      // new frame latches the byte
         uon   = 1'b1;
         upos  = 0;
         ubyte = tx_byte;
      end
      if (!uon) begin
         mtx = 1'b1;
      end else if (upos < BAUD_DIV) begin
         mtx = 1'b0;                                  // start bit
      end else if (upos >= 9 * BAUD_DIV) begin
         mtx = 1'b1;                                  // stop bit
      end else begin
         mtx = ubyte[upos / BAUD_DIV - 1];            // data lsb first
      end
      check("o_done", 32'(done), 32'(cyc - 1 == done_at));
      check("o_busy", 32'(busy), 32'(mstate != 0));
      check("o_tx", 32'(tx), 32'(mtx));
   endtask

   task automatic tick();
      logic [31:0] r;
      @(negedge clk);
      if (rst_n) model_step();
      r     = lcg_next();
      probe = r[23:16];
      if (mstate == 2 && wait_cnt >= FORCE_AFTER) probe[mchn] = ~mprev[mchn]; // force trigger
   endtask

   task automatic reset_dut();
      rst_n = 1'b0;
      repeat (5) @(negedge clk);
      cyc     = 0;
      mc      = '0;
      mmask   = '0;
      mstate  = 0;
      mprev   = '0;
      mhold   = ARM_DELAY;                            // holdoff starts at release
      mactive = 1'b1;
      uon     = 1'b0;
      upos    = 0;
      mtx     = 1'b1;
      done_at = -10;
      rst_n   = 1'b1;
   endtask

   task automatic wait_done();
      tick();
      while (!done) tick();
      check("o_start_addr", 32'(start_addr), 32'(mstart));
   endtask

   task automatic read_trace();
      for (int i = 0; i < 1024; i++) begin
         rd_addr = analyser_pkg::addr_t'((mstart + i) & 1023);
         tick();
         rd_buf[i] = rd_data;
         check("o_rd_data", 32'(rd_data), 32'(mmem[(mstart + i) & 1023]));
      end
      if (mpre > 0) begin
         check("trigger entry", 32'(trig_met(mmode, rd_buf[mpre-1][mchn], rd_buf[mpre][mchn])), 1);
      end
   endtask

   task automatic single_capture();
      reset_dut();
      run = 1'b1;                                    // needed when holdoff runs out
      while (!busy) tick();
      run = 1'b0;                                    // no re-arm after this one
      wait_done();
      read_trace();
   endtask

   initial begin
      #(NUM_CAPS * CAP_CYCLES * CLK_PERIOD);
      fail_run("watchdog timeout, capture never finished");
   end

   initial begin
      logic [31:0] r;
      analyser_pkg::sample_t b;
      rst_n    = 1'b0;
      probe    = '0;
      run      = 1'b0;
      uart_en  = 1'b0;
      tx_byte  = '0;
      chn_sel  = '0;
      mode_sel = analyser_pkg::TRIG_RISE;
      freq_sel = '0;
      pre_num  = '0;
      rd_addr  = '0;
      reset_dut();
      check("o_done", 32'(done), 0);
      check("o_busy", 32'(busy), 0);
      check("o_tx", 32'(tx), 1);
      check("o_start_addr", 32'(start_addr), 0);
      for (int k = 0; k < 6; k++) begin                // random trigger setups
         r        = lcg_next();
         chn_sel  = r[18:16];
         mode_sel = analyser_pkg::trig_mode_t'(r[26:24] % 3'd5);
         freq_sel = analyser_pkg::freq_sel_t'(r[29:28]);
         r        = lcg_next();
         pre_num  = r[25:16];
         single_capture();
      end
      r        = lcg_next();                           // uart self-test capture
      tx_byte  = 8'hFF << (1 + r[18:16] % 3'd7);       // only falling edge is the start bit
      pre_num  = analyser_pkg::addr_t'(1 + r[31:20] % 12'd700);
      freq_sel = '0;
      uart_en  = 1'b1;
      single_capture();
      check("start bit before", 32'(rd_buf[mpre-1][4]), 1);
      check("start bit", 32'(rd_buf[mpre][4]), 0);
      for (int i = 0; i < 8; i++) b[i] = rd_buf[mpre + BAUD_DIV * (i + 1) + BAUD_DIV / 2][4];
      check("uart byte", 32'(b), 32'(tx_byte));
      uart_en = 1'b0;                                  // free running re-arm
      freq_sel = 4'd0;
      run = 1'b1;
      reset_dut();
      wait_done();
      freq_sel = 4'd1;
      wait_done();
      freq_sel = 4'd3;
      while (!busy) tick();
      run = 1'b0;
      wait_done();
      repeat (4 * ARM_DELAY + 20) begin
         tick();
         check("o_busy", 32'(busy), 0);
      end
      read_trace();
      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== logic/top_analyser.sv ====
`timescale 1ns/1ps

module top_analyser #(
   parameter int BAUD_DIV  = analyser_pkg::DEF_BAUD_DIV,
   parameter int ARM_DELAY = analyser_pkg::DEF_ARM_DELAY
) (
   input  logic                     sys_clk,
   input  logic                     i_rst_n,
   input  analyser_pkg::sample_t    i_probe,      // external probe channels
   input  logic                     i_run,        // keep re-arming
   input  logic                     i_uart_en,    // self-test on channel 4
   input  analyser_pkg::sample_t    i_tx_byte,    // self-test byte
   input  analyser_pkg::chan_t      i_chn_sel,
   input  analyser_pkg::trig_mode_t i_mode_sel,
   input  analyser_pkg::freq_sel_t  i_freq_sel,
   input  analyser_pkg::addr_t      i_pre_num,
   input  analyser_pkg::addr_t      i_rd_addr,    // trace read port
   output analyser_pkg::sample_t    o_rd_data,
   output analyser_pkg::addr_t      o_start_addr, // trace begins here
   output logic                     o_done,
   output logic                     o_busy,
   output logic                     o_tx          // uart line out
);

   logic                     clken;     // sample strobe
   logic                     arm;
   logic                     finished;
   logic                     tx;
   logic                     wr_en;
   analyser_pkg::addr_t      wr_addr;
   analyser_pkg::sample_t    wr_data;
   analyser_pkg::sample_t    sample;    // probe after uart override
   analyser_pkg::chan_t      chn_sel;
   analyser_pkg::trig_mode_t mode_sel;

   // uart test mode triggers on the start bit of the serial line
   always_comb begin
      sample   = i_probe;
      chn_sel  = i_chn_sel;
      mode_sel = i_mode_sel;
      if (i_uart_en) begin
         sample[analyser_pkg::UART_CHAN] = tx; // replace probe bit
         chn_sel  = analyser_pkg::UART_CHAN;
         mode_sel = analyser_pkg::TRIG_FALL;
      end
   end

   freq_div u_freq_div (
      .sys_clk     (  sys_clk      ), // input
      .i_rst_n     (  i_rst_n      ), // input
      .i_freq_sel  (  i_freq_sel   ), // input
      .o_clken     (  clken        )  // output
   );

   uart_tx #(
      .BAUD_DIV    (  BAUD_DIV     )
   ) u_uart_tx (
      .sys_clk     (  sys_clk      ), // input
      .i_rst_n     (  i_rst_n      ), // input
      .i_enable    (  i_uart_en    ), // input
      .i_data      (  i_tx_byte    ), // input
      .o_tx        (  tx           )  // output
   );

   sample_ctrl u_sample_ctrl (
      .sys_clk     (  sys_clk      ), // input
      .i_rst_n     (  i_rst_n      ), // input
      .i_clken     (  clken        ), // input
      .i_arm       (  arm          ), // input
      .i_chn_sel   (  chn_sel      ), // input
      .i_mode_sel  (  mode_sel     ), // input
      .i_pre_num   (  i_pre_num    ), // input
      .i_data      (  sample       ), // input
      .o_wr_en     (  wr_en        ), // output
      .o_wr_addr   (  wr_addr      ), // output
      .o_wr_data   (  wr_data      ), // output
      .o_start_addr(  o_start_addr ), // output
      .o_finished  (  finished     ), // output
      .o_busy      (  o_busy       )  // output
   );

   capture_ram u_capture_ram (
      .sys_clk     (  sys_clk      ), // input
      .i_wr_en     (  wr_en        ), // input
      .i_wr_addr   (  wr_addr      ), // input
      .i_wr_data   (  wr_data      ), // input
      .i_rd_addr   (  i_rd_addr    ), // input
      .o_rd_data   (  o_rd_data    )  // output
   );

   pulse_gen #(
      .ARM_DELAY   (  ARM_DELAY    )
   ) u_pulse_gen (
      .sys_clk     (  sys_clk      ), // input
      .i_rst_n     (  i_rst_n      ), // input
      .i_finished  (  finished     ), // input
      .i_run       (  i_run        ), // input
      .o_arm       (  arm          )  // output
   );

   assign o_done = finished; // end of capture
   assign o_tx   = tx;

endmodule

// ==== logic/pulse_gen.sv ====
`timescale 1ns/1ps

module pulse_gen #(
   parameter int ARM_DELAY = analyser_pkg::DEF_ARM_DELAY // holdoff clocks, >= 1
) (
   input  logic sys_clk,
   input  logic i_rst_n,
   input  logic i_finished, // capture done, restart holdoff
   input  logic i_run,      // allow a new arm
   output logic o_arm       // single cycle arm strobe
);

   localparam int CNT_W = $clog2(ARM_DELAY + 1);

   logic [CNT_W-1:0] hold_cnt; // clocks left before arm
   logic             active;   // holdoff in progress

   // fires only when the holdoff runs out and run is set
   assign o_arm = active && (hold_cnt == '0) && i_run;

   always_ff @(posedge sys_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         hold_cnt <= CNT_W'(ARM_DELAY);     // counts from reset release
         active   <= 1'b1;
      end else if (i_finished) begin
         hold_cnt <= CNT_W'(ARM_DELAY - 1); // arm lands ARM_DELAY after finished
         active   <= 1'b1;
      end else if (active) begin
         if (hold_cnt == '0) begin
            active <= 1'b0;                 // one shot, run low means skip
         end else begin
            hold_cnt <= hold_cnt - 1'b1;
         end
      end
   end

endmodule

// ==== logic/capture_ram.sv ====
`timescale 1ns/1ps

module capture_ram (
   input  logic                  sys_clk,
   input  logic                  i_wr_en,   // write port from sample_ctrl
   input  analyser_pkg::addr_t   i_wr_addr,
   input  analyser_pkg::sample_t i_wr_data,
   input  analyser_pkg::addr_t   i_rd_addr, // display / bench side
   output analyser_pkg::sample_t o_rd_data  // valid one cycle after address
);

   // simple dual port, maps onto one block ram
   analyser_pkg::sample_t mem [analyser_pkg::CAP_DEPTH];

   always_ff @(posedge sys_clk) begin
      if (i_wr_en) begin
         mem[i_wr_addr] <= i_wr_data;
      end
   end

   always_ff @(posedge sys_clk) begin
      o_rd_data <= mem[i_rd_addr]; // registered read
   end

endmodule

// ==== logic/sample_ctrl.sv ====
`timescale 1ns/1ps

module sample_ctrl (
   input  logic                     sys_clk,
   input  logic                     i_rst_n,
   input  logic                     i_clken,      // sample strobe
   input  logic                     i_arm,        // start a capture when idle
   input  analyser_pkg::chan_t      i_chn_sel,    // trigger channel
   input  analyser_pkg::trig_mode_t i_mode_sel,   // trigger condition
   input  analyser_pkg::addr_t      i_pre_num,    // samples kept before trigger
   input  analyser_pkg::sample_t    i_data,       // probe sample
   output logic                     o_wr_en,      // memory write strobe
   output analyser_pkg::addr_t      o_wr_addr,
   output analyser_pkg::sample_t    o_wr_data,
   output analyser_pkg::addr_t      o_start_addr, // first trace entry
   output logic                     o_finished,   // capture complete pulse
   output logic                     o_busy        // armed or capturing
);

   typedef enum logic [2:0] {
      IDLE,  // waiting for arm
      PRE,   // filling pre-trigger window
      WAIT,  // ring runs until trigger
      POST,  // filling rest of trace
      DONE   // last write issued
   } ctrl_state_t;

   ctrl_state_t              state;
   analyser_pkg::addr_t      wr_ptr;      // ring write pointer with wrap
   analyser_pkg::addr_t      cnt;         // samples left in PRE or POST
   analyser_pkg::sample_t    prev;        // previous clken sample
   analyser_pkg::chan_t      chn_q;       // settings held for the capture
   analyser_pkg::trig_mode_t mode_q;
   analyser_pkg::addr_t      pre_q;
   analyser_pkg::addr_t      start_q;
   logic                     cur_bit;     // selected channel now
   logic                     prev_bit;    // selected channel one sample ago
   logic                     trig_hit;    // condition met on this sample
   logic                     sampling;    // sample goes into memory
   logic                     wr_en_q;
   logic                     finished_q;

   assign sampling = i_clken && ((state == PRE) || (state == WAIT) || (state == POST));
   assign cur_bit  = i_data[chn_q];
   assign prev_bit = prev[chn_q];

   always_comb begin
      case (mode_q)
         analyser_pkg::TRIG_RISE: trig_hit = !prev_bit && cur_bit;
         analyser_pkg::TRIG_FALL: trig_hit = prev_bit && !cur_bit;
         analyser_pkg::TRIG_HIGH: trig_hit = cur_bit;
         analyser_pkg::TRIG_LOW:  trig_hit = !cur_bit;
         analyser_pkg::TRIG_NOW:  trig_hit = 1'b1;    // first WAIT sample
         default:                 trig_hit = 1'b0;    // unused codes never fire
      endcase
   end

   always_ff @(posedge sys_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state      <= IDLE;
         wr_ptr     <= '0;
         cnt        <= '0;
         prev       <= '0;
         chn_q      <= '0;
         mode_q     <= analyser_pkg::TRIG_RISE;
         pre_q      <= '0;
         start_q    <= '0;
         wr_en_q    <= 1'b0;
         finished_q <= 1'b0;
      end else begin
         wr_en_q    <= sampling;               // write lands one cycle after clken
         finished_q <= (state == DONE);        // one cycle after last write
         if (i_clken) begin
            prev <= i_data;                    // edge reference, every sample
         end
         if (sampling) begin
            wr_ptr <= wr_ptr + 1'b1;           // wraps at depth
         end
         case (state)
            IDLE: if (i_arm) begin
               wr_ptr <= '0;                   // capture always starts at 0
               chn_q  <= i_chn_sel;
               mode_q <= i_mode_sel;
               pre_q  <= i_pre_num;
               cnt    <= i_pre_num;
               state  <= (i_pre_num == '0) ? WAIT : PRE; // empty window skips PRE
            end
            PRE: if (i_clken) begin
               cnt <= cnt - 1'b1;
               if (cnt == 10'd1) begin
                  state <= WAIT;               // pre window full
               end
            end
            WAIT: if (i_clken && trig_hit) begin
               start_q <= wr_ptr - pre_q;      // trigger addr minus pre mod depth
               cnt     <= ~pre_q;              // depth - pre - 1 still to write
               state   <= (pre_q == '1) ? DONE : POST;
            end
            POST: if (i_clken) begin
               cnt <= cnt - 1'b1;
               if (cnt == 10'd1) begin
                  state <= DONE;               // trace complete
               end
            end
            DONE: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // write address and data for the memory
   always_ff @(posedge sys_clk) begin
      if (sampling) begin
         o_wr_addr <= wr_ptr;
         o_wr_data <= i_data;
      end
   end

   assign o_wr_en      = wr_en_q;
   assign o_finished   = finished_q;
   assign o_start_addr = start_q;
   assign o_busy       = (state != IDLE);      // drops with the finished pulse

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
   parameter int BAUD_DIV = analyser_pkg::DEF_BAUD_DIV // clocks per bit
) (
   input  logic                  sys_clk,
   input  logic                  i_rst_n,
   input  logic                  i_enable, // keep sending frames
   input  analyser_pkg::sample_t i_data,   // byte to repeat
   output logic                  o_tx      // serial line, idles high
);

   localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   tx_state_t             state;
   logic [CNT_W-1:0]      baud_cnt; // clocks into current bit
   logic [2:0]            bit_idx;  // data bit being sent
   logic                  baud_end; // last clock of a bit
   logic                  load;     // latch a new byte
   logic                  shift;    // move to next data bit
   logic                  tx_q;
   analyser_pkg::sample_t shreg;    // byte in flight, lsb out first

   assign baud_end = (baud_cnt == CNT_W'(BAUD_DIV - 1));

   // byte latched as a start bit begins
   assign load  = i_enable && ((state == TX_IDLE) || (state == TX_STOP && baud_end));
   assign shift = baud_end && ((state == TX_START) || (state == TX_DATA));
   assign o_tx  = tx_q;

   always_ff @(posedge sys_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state    <= TX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
         tx_q     <= 1'b1;                 // line idle
      end else begin
         if (state == TX_IDLE || baud_end) begin
            baud_cnt <= '0;                // each bit starts from zero
         end else begin
            baud_cnt <= baud_cnt + 1'b1;
         end
         case (state)
            TX_IDLE: if (i_enable) begin
               state <= TX_START;
               tx_q  <= 1'b0;              // start bit
            end
            TX_START: if (baud_end) begin
               state   <= TX_DATA;
               bit_idx <= '0;
               tx_q    <= shreg[0];        // data bit 0
            end
            TX_DATA: if (baud_end) begin
               if (bit_idx == 3'd7) begin
                  state <= TX_STOP;
                  tx_q  <= 1'b1;           // stop bit
               end else begin
                  bit_idx <= bit_idx + 3'd1;
                  tx_q    <= shreg[0];     // already shifted to next bit
               end
            end
            TX_STOP: if (baud_end) begin
               if (i_enable) begin
                  state <= TX_START;       // back to back frames
                  tx_q  <= 1'b0;
               end else begin
                  state <= TX_IDLE;        // frame done, line stays high
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (load) begin
         shreg <= i_data;
      end else if (shift) begin
         shreg <= shreg >> 1;              // next bit into lsb
      end
   end

endmodule

// ==== logic/freq_div.sv ====
`timescale 1ns/1ps

module freq_div (
   input  logic                    sys_clk,
   input  logic                    i_rst_n,
   input  analyser_pkg::freq_sel_t i_freq_sel, // period exponent
   output logic                    o_clken     // one cycle per period
);

   logic [15:0] cnt;      // position inside current period
   logic [15:0] mask_q;   // period mask held until the wrap
   logic [15:0] mask_now; // mask from the live select
   logic [15:0] mask_eff; // mask used in this cycle

   assign mask_now = (16'd1 << i_freq_sel) - 16'd1; // 2**sel - 1

   // new select only taken on the first cycle of a period
   assign mask_eff = (cnt == '0) ? mask_now : mask_q;

   assign o_clken = (cnt == mask_eff); // last cycle of the period

   always_ff @(posedge sys_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt    <= '0;             // period restarts at release
         mask_q <= '0;
      end else begin
         if (cnt == '0) begin
            mask_q <= mask_now;    // freeze mask for this period
         end
         if (o_clken) begin
            cnt <= '0;             // wrap
         end else begin
            cnt <= cnt + 16'd1;
         end
      end
   end

endmodule

// ==== logic/analyser_pkg.sv ====
package analyser_pkg;

   // probe and memory widths
   typedef logic [7:0] sample_t;   // one sample of all 8 probe channels
   typedef logic [9:0] addr_t;     // capture memory address, sets depth
   typedef logic [2:0] chan_t;     // trigger channel index
   typedef logic [3:0] freq_sel_t; // sample period is 2**freq_sel clocks

   // trigger condition on the selected channel
   typedef enum logic [2:0] {
      TRIG_RISE = 3'd0, // 0 -> 1 edge
      TRIG_FALL = 3'd1, // 1 -> 0 edge
      TRIG_HIGH = 3'd2, // level high
      TRIG_LOW  = 3'd3, // level low
      TRIG_NOW  = 3'd4  // first sample after pre-fill
   } trig_mode_t;

   // capture memory depth follows the address width
   localparam int CAP_DEPTH = 1 << $bits(addr_t);

   // probe channel that carries the uart self-test line
   localparam chan_t UART_CHAN = 3'd4;

   // default clocks per uart bit
   localparam int DEF_BAUD_DIV = 16;

   // default holdoff before each arm pulse
   localparam int DEF_ARM_DELAY = 8;

endpackage
